// ==== common/board_power_pkg.sv ====
package board_power_pkg;

  // sequencer states
  typedef enum logic [2:0] {
    off,
    atx_wait,
    rail_step,
    pg_wait,
    on,
    fault
  } pwr_state_t;

  typedef logic [2:0]  rail_stage_t;      // rail steps released so far
  typedef logic [1:0]  power_cause_t;     // why the board is off
  typedef logic        wait_sel_t;        // timer length select
  typedef logic [11:0] timer_count_t;
  typedef logic [4:0]  debounce_count_t;

  // 2V5, 1V8, 1V5, 1V2, 1V0 and then the MGT group
  localparam rail_stage_t RAIL_STAGES = 3'd6;

  localparam power_cause_t CAUSE_NONE = 2'd0;  // never powered up
  localparam power_cause_t CAUSE_ATX  = 2'd1;  // ATX power-good timeout or loss
  localparam power_cause_t CAUSE_RAIL = 2'd2;  // rail power-good timeout or loss
  localparam power_cause_t CAUSE_USER = 2'd3;  // turned off by the button

  localparam wait_sel_t WAIT_STEP    = 1'b0;
  localparam wait_sel_t WAIT_TIMEOUT = 1'b1;

  // cycle counts, short enough for simulation
  localparam timer_count_t RAIL_STEP_CYCLES  = 12'd40;
  localparam timer_count_t PG_TIMEOUT_CYCLES = 12'd400;

  localparam debounce_count_t DEBOUNCE_CYCLES = 5'd16;

  // free-running LED blink counter
  localparam int BLINK_WIDTH      = 8;
  localparam int POWER_BLINK_BIT  = 5;  // fast blink, bad power-down
  localparam int ACTION_BLINK_BIT = 7;  // slow blink, board off

endpackage

// ==== common/rail_ctrl_if.sv ====
`timescale 1ns/1ps

interface rail_ctrl_if;
  import board_power_pkg::*;

  logic        atx_on;      // ATX supply requested
  rail_stage_t rail_stage;  // number of released rail steps
  logic        atx_good;    // synchronized ATX power-good
  logic        rails_good;  // all released rails report good

  modport seq (
    output atx_on, rail_stage,
    input  atx_good, rails_good
  );

  modport drv (
    input  atx_on, rail_stage,
    output atx_good, rails_good
  );

endinterface

// ==== design/button_debouncer.sv ====
`timescale 1ns/1ps

module button_debouncer (
  input  logic gclk40,
  input  logic reset_i,
  input  logic button_n_i,
  output logic press_o
);
  import board_power_pkg::*;

  logic [1:0]      sync_q;    // two-flop synchronizer
  logic            stable_q;  // debounced level, active low
  debounce_count_t count_q;
  logic            changing;
  logic            settled;

  assign changing = (sync_q[1] != stable_q);
  assign settled  = changing && (count_q == DEBOUNCE_CYCLES);

  always_ff @(posedge gclk40) begin
    if (reset_i) begin
      sync_q <= 2'b11;  // button released
    end else begin
      sync_q <= {sync_q[0], button_n_i};
    end
  end

  always_ff @(posedge gclk40) begin
    if (reset_i) begin
      stable_q <= 1'b1;
      count_q  <= '0;
      press_o  <= 1'b0;
    end else begin
      press_o <= settled && !sync_q[1];  // stable falling edge only
      if (settled) begin
        stable_q <= sync_q[1];
        count_q  <= '0;
      end else if (changing) begin
        count_q <= count_q + 1'b1;
      end else begin
        count_q <= '0;  // bounce back to the old level restarts the count
      end
    end
  end

endmodule

// ==== power/sequence_timer.sv ====
`timescale 1ns/1ps

module sequence_timer (
  input  logic                       gclk40,
  input  logic                       reset_i,
  input  logic                       start_i,
  input  board_power_pkg::wait_sel_t wait_sel_i,
  output logic                       expired_o
);
  import board_power_pkg::*;

  timer_count_t count_q;
  timer_count_t load_value;
  logic         running_q;

  assign load_value = (wait_sel_i == WAIT_TIMEOUT) ? PG_TIMEOUT_CYCLES : RAIL_STEP_CYCLES;

  // a start in the same cycle hides a stale expiry
  assign expired_o = running_q && (count_q == timer_count_t'(1)) && !start_i;

  always_ff @(posedge gclk40) begin
    if (reset_i) begin
      running_q <= 1'b0;
    end else if (start_i) begin
      running_q <= 1'b1;
    end else if (expired_o) begin
      running_q <= 1'b0;  // idle until the next start
    end
  end

  always_ff @(posedge gclk40) begin
    if (start_i) begin
      count_q <= load_value;
    end else if (running_q) begin
      count_q <= count_q - 1'b1;
    end
  end

endmodule

// ==== power/power_sequencer.sv ====
`timescale 1ns/1ps

module power_sequencer (
  input  logic                          gclk40,
  input  logic                          reset_i,
  input  logic                          press_i,
  input  logic                          expired_i,
  rail_ctrl_if.seq                      rail,
  output logic                          timer_start_o,
  output board_power_pkg::wait_sel_t    timer_sel_o,
  output logic                          power_ok_o,
  output board_power_pkg::power_cause_t cause_o
);
  import board_power_pkg::*;

  pwr_state_t   state_q;
  pwr_state_t   state_d;
  rail_stage_t  stage_q;
  logic         stage_inc;
  logic         atx_on_q;
  power_cause_t cause_q;
  power_cause_t cause_d;
  logic         start_q;
  logic         start_d;
  wait_sel_t    sel_q;
  wait_sel_t    sel_d;
  logic         powered_d;

  // next state and the timer request that goes with it
  always_comb begin
    state_d   = state_q;
    cause_d   = cause_q;
    stage_inc = 1'b0;
    start_d   = 1'b0;
    sel_d     = sel_q;
    case (state_q)
      off, fault: begin
        if (press_i) begin
          state_d = atx_wait;
          start_d = 1'b1;
          sel_d   = WAIT_TIMEOUT;
        end
      end
      atx_wait: begin
        if (rail.atx_good) begin
          state_d = rail_step;
          start_d = 1'b1;
          sel_d   = WAIT_STEP;
        end else if (expired_i) begin
          state_d = fault;
          cause_d = CAUSE_ATX;
        end
      end
      rail_step: begin
        if (!rail.atx_good) begin
          state_d = fault;
          cause_d = CAUSE_ATX;
        end else if (expired_i) begin
          stage_inc = 1'b1;
          start_d   = 1'b1;
          if (stage_q == RAIL_STAGES - 3'd1) begin
            state_d = pg_wait;  // last step, MGT group released
            sel_d   = WAIT_TIMEOUT;
          end else begin
            sel_d = WAIT_STEP;
          end
        end
      end
      pg_wait: begin
        if (!rail.atx_good) begin
          state_d = fault;
          cause_d = CAUSE_ATX;
        end else if (rail.rails_good) begin
          state_d = on;
        end else if (expired_i) begin
          state_d = fault;
          cause_d = CAUSE_RAIL;
        end
      end
      on: begin
        if (!rail.atx_good) begin
          state_d = fault;
          cause_d = CAUSE_ATX;
        end else if (!rail.rails_good) begin
          state_d = fault;
          cause_d = CAUSE_RAIL;
        end else if (press_i) begin
          state_d = off;
          cause_d = CAUSE_USER;
        end
      end
      default: begin
        state_d = off;
      end
    endcase
  end

  assign powered_d = (state_d != off) && (state_d != fault);

  always_ff @(posedge gclk40) begin
    if (reset_i) begin
      state_q  <= off;
      stage_q  <= '0;
      atx_on_q <= 1'b0;
      cause_q  <= CAUSE_NONE;
      start_q  <= 1'b0;
      sel_q    <= WAIT_STEP;
    end else begin
      state_q  <= state_d;
      atx_on_q <= powered_d;
      cause_q  <= cause_d;
      start_q  <= start_d;
      sel_q    <= sel_d;
      if (!powered_d) begin
        stage_q <= '0;  // drop all rails together with ATX
      end else if (stage_inc) begin
        stage_q <= stage_q + 1'b1;
      end
    end
  end

  assign rail.atx_on     = atx_on_q;
  assign rail.rail_stage = stage_q;
  assign timer_start_o   = start_q;
  assign timer_sel_o     = sel_q;
  assign power_ok_o      = (state_q == on);
  assign cause_o         = cause_q;

endmodule

// ==== power/rail_driver.sv ====
`timescale 1ns/1ps

module rail_driver (
  input  logic       gclk40,
  input  logic       reset_i,
  input  logic       atx_pwr_ok_i,
  input  logic       aux_3v3_pg_i,
  input  logic [2:0] mgt_pg_i,
  rail_ctrl_if.drv   rail,
  output logic       atx_ps_on_n_o,
  output logic       atx_load_res_off_o,
  output logic       track_2v5_o,
  output logic [4:0] inhibit_o,  // bit 0 is 2V5 through bit 4 for 1V0
  output logic [2:0] mgt_en_o
);
  import board_power_pkg::*;

  logic [4:0] pg_meta_q;  // {mgt, aux_3v3, atx}
  logic [4:0] pg_sync_q;
  logic       atx_ok;
  logic       aux_ok;
  logic [2:0] mgt_ok;
  logic       mgt_released;

  always_ff @(posedge gclk40) begin
    if (reset_i) begin
      pg_meta_q <= '0;
      pg_sync_q <= '0;
    end else begin
      pg_meta_q <= {mgt_pg_i, aux_3v3_pg_i, atx_pwr_ok_i};
      pg_sync_q <= pg_meta_q;
    end
  end

  assign atx_ok       = pg_sync_q[0];
  assign aux_ok       = pg_sync_q[1];
  assign mgt_ok       = pg_sync_q[4:2];
  assign mgt_released = (rail.rail_stage == RAIL_STAGES);

  assign rail.atx_good   = atx_ok;
  assign rail.rails_good = aux_ok && (!mgt_released || (&mgt_ok));

  always_ff @(posedge gclk40) begin
    if (reset_i) begin
      atx_ps_on_n_o      <= 1'b1;
      atx_load_res_off_o <= 1'b0;
      track_2v5_o        <= 1'b0;
      inhibit_o          <= '1;
      mgt_en_o           <= '0;
    end else begin
      atx_ps_on_n_o      <= !rail.atx_on;
      atx_load_res_off_o <= rail.atx_on;  // load resistor out while ATX is on
      track_2v5_o        <= (rail.rail_stage != '0);
      for (int k = 0; k < $bits(inhibit_o); k++) begin
        inhibit_o[k] <= !(rail.rail_stage > k);
      end
      mgt_en_o <= {3{mgt_released}};
    end
  end

endmodule

// ==== design/status_led.sv ====
`timescale 1ns/1ps

module status_led (
  input  logic                          gclk40,
  input  logic                          reset_i,
  input  logic                          power_ok_i,
  input  board_power_pkg::power_cause_t cause_i,
  output logic [1:0]                    chs_led_n_o
);
  import board_power_pkg::*;

  logic [BLINK_WIDTH-1:0] blink_q;
  logic                   bad_power_down;
  logic                   power_led;
  logic                   action_led;

  always_ff @(posedge gclk40) begin
    if (reset_i) begin
      blink_q <= '0;
    end else begin
      blink_q <= blink_q + 1'b1;
    end
  end

  assign bad_power_down = (cause_i == CAUSE_ATX) || (cause_i == CAUSE_RAIL);

  // solid when powered, fast blink after a supply fault
  always_comb begin
    if (power_ok_i) begin
      power_led = 1'b1;
    end else if (bad_power_down) begin
      power_led = blink_q[POWER_BLINK_BIT];
    end else begin
      power_led = 1'b0;
    end
  end

  assign action_led = power_ok_i ? 1'b1 : blink_q[ACTION_BLINK_BIT];  // slow blink while off

  assign chs_led_n_o = ~{action_led, power_led};  // LEDs are active low

endmodule

// ==== design/board_power_top.sv ====
`timescale 1ns/1ps

module board_power_top (
  input  logic                          gclk40,
  input  logic                          reset_i,
  input  logic                          chs_powerdown_n_i,
  input  logic                          atx_pwr_ok_i,
  input  logic                          aux_3v3_pg_i,
  input  logic [2:0]                    mgt_pg_i,
  output logic                          atx_ps_on_n_o,
  output logic                          atx_load_res_off_o,
  output logic                          track_2v5_o,
  output logic [4:0]                    inhibit_o,
  output logic [2:0]                    mgt_en_o,
  output logic                          power_ok_o,
  output board_power_pkg::power_cause_t power_cause_o,
  output logic [1:0]                    chs_led_n_o
);
  import board_power_pkg::*;

  logic      press;
  logic      timer_start;
  wait_sel_t timer_sel;
  logic      timer_expired;

  rail_ctrl_if rail_if ();

  button_debouncer button_debouncer_inst (
    .gclk40     (gclk40),
    .reset_i    (reset_i),
    .button_n_i (chs_powerdown_n_i),
    .press_o    (press)
  );

  sequence_timer sequence_timer_inst (
    .gclk40     (gclk40),
    .reset_i    (reset_i),
    .start_i    (timer_start),
    .wait_sel_i (timer_sel),
    .expired_o  (timer_expired)
  );

  power_sequencer power_sequencer_inst (
    .gclk40        (gclk40),
    .reset_i       (reset_i),
    .press_i       (press),
    .expired_i     (timer_expired),
    .rail          (rail_if.seq),
    .timer_start_o (timer_start),
    .timer_sel_o   (timer_sel),
    .power_ok_o    (power_ok_o),
    .cause_o       (power_cause_o)
  );

  rail_driver rail_driver_inst (
    .gclk40             (gclk40),
    .reset_i            (reset_i),
    .atx_pwr_ok_i       (atx_pwr_ok_i),
    .aux_3v3_pg_i       (aux_3v3_pg_i),
    .mgt_pg_i           (mgt_pg_i),
    .rail               (rail_if.drv),
    .atx_ps_on_n_o      (atx_ps_on_n_o),
    .atx_load_res_off_o (atx_load_res_off_o),
    .track_2v5_o        (track_2v5_o),
    .inhibit_o          (inhibit_o),
    .mgt_en_o           (mgt_en_o)
  );

  status_led status_led_inst (
    .gclk40      (gclk40),
    .reset_i     (reset_i),
    .power_ok_i  (power_ok_o),
    .cause_i     (power_cause_o),
    .chs_led_n_o (chs_led_n_o)
  );

endmodule

// ==== verif/board_power_tb.sv ====
`timescale 1ns/1ps

module board_power_tb;
  import board_power_pkg::*;

  localparam int MAX_VECTORS       = 32;
  localparam int CYCLES_PER_VECTOR = 2000;
  localparam int LONG_PRESS        = int'(DEBOUNCE_CYCLES) + 6;

  logic         gclk40 = 1'b0;
  logic         reset_i, chs_powerdown_n_i, atx_pwr_ok_i, aux_3v3_pg_i;
  logic [2:0]   mgt_pg_i;
  logic         atx_ps_on_n_o, atx_load_res_off_o, track_2v5_o, power_ok_o;
  logic [4:0]   inhibit_o;
  logic [2:0]   mgt_en_o;
  power_cause_t power_cause_o;
  logic [1:0]   chs_led_n_o;

  logic [8*24-1:0] vec_name [MAX_VECTORS];
  int              vec_data [MAX_VECTORS][7];  // columns after the name
  int              num_vectors, cycle_count, cycle_limit, mismatches, other_errors;
  int              cfg_atx_ok, cfg_atx_delay, cfg_rails_ok, cfg_drop;
  int              atx_age, on_age;  // board model cycle counters
  string           test_name;

  board_power_top board_power_top_inst (.*);

  always #10 gclk40 = ~gclk40;

  always @(posedge gclk40) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("timeout after %0d cycles, the DUT stopped responding", cycle_count);
      $display("Test failed");
      $finish;
    end
  end

  // board model answering the supply enables
  always @(posedge gclk40) begin
    #2;
    if (atx_ps_on_n_o) begin
      atx_age = 0;
      on_age  = 0;
    end else begin
      atx_age = atx_age + 1;
    end
    if (power_ok_o) begin
      on_age = on_age + 1;
    end
    atx_pwr_ok_i = (cfg_atx_ok != 0) && !atx_ps_on_n_o && (atx_age >= cfg_atx_delay);
    aux_3v3_pg_i = atx_pwr_ok_i && !((cfg_drop > 0) && (on_age >= cfg_drop));  // drop after on
    mgt_pg_i     = (cfg_rails_ok != 0) ? mgt_en_o : 3'b000;
  end

  task automatic tick();
    @(posedge gclk40);
    #2;
  endtask

  task automatic report_error(input string msg);
    $display("error in %0s: %0s", test_name, msg);
    other_errors++;
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("mismatch %0s %0s: expected %b, actual %b", test_name, what, exp, act);
      mismatches++;
    end
  endtask

  task automatic check_cause(input string what, input power_cause_t exp, input power_cause_t act);
    if (act !== exp) begin
      $display("mismatch %0s %0s: expected %0d, actual %0d", test_name, what, exp, act);
      mismatches++;
    end
  endtask

  // stage whose pattern matches the rail outputs or -1
  function automatic int rail_stage_seen();
    int         s;
    int         k;
    logic [4:0] inh;
    for (s = 0; s <= int'(RAIL_STAGES); s++) begin
      for (k = 0; k < 5; k++) begin
        inh[k] = (s <= k);
      end
      if (track_2v5_o === (s >= 1) && inhibit_o === inh && mgt_en_o === {3{s == 6}}) begin
        return s;
      end
    end
    return -1;
  endfunction

  task automatic press_button(input int hold);
    chs_powerdown_n_i = 1'b0;
    repeat (hold) tick();
    chs_powerdown_n_i = 1'b1;
    tick();
  endtask

  task automatic wait_supply(input logic level, input int limit, input string what);
    int n;
    n = 0;
    while (atx_ps_on_n_o !== level && n < limit) begin
      tick();
      n++;
    end
    if (atx_ps_on_n_o !== level) begin
      report_error(what);
    end
  endtask

  task automatic check_all_off();
    check_bit("atx_ps_on_n_o", 1'b1, atx_ps_on_n_o);
    check_bit("atx_load_res_off_o", 1'b0, atx_load_res_off_o);
    check_bit("power_ok_o", 1'b0, power_ok_o);
    if (rail_stage_seen() != 0) begin
      report_error("rail outputs did not turn off together with the ATX supply");
    end
  endtask

  task automatic check_power_blink();
    bit seen_on;
    bit seen_off;
    seen_on  = 1'b0;
    seen_off = 1'b0;
    repeat (80) begin  // longer than one blink period
      tick();
      seen_on  = seen_on || (chs_led_n_o[0] == 1'b0);
      seen_off = seen_off || (chs_led_n_o[0] == 1'b1);
    end
    if (!(seen_on && seen_off)) begin
      report_error("power LED does not blink after a supply fault");
    end
  endtask

  // follows the rail outputs until the board is on or has dropped out again
  task automatic run_power_up(output int max_stage);
    int last;
    int s;
    int since_step;
    int n;
    last       = 0;
    since_step = 0;
    n          = 0;
    while (!power_ok_o && !atx_ps_on_n_o && n < CYCLES_PER_VECTOR) begin
      tick();
      n++;
      since_step++;
      s = rail_stage_seen();
      if (!atx_ps_on_n_o && s != last) begin
        if (s < 0) begin
          report_error("rail outputs released out of order");
        end else if (s != last + 1) begin
          report_error($sformatf("rail stage jumped from %0d to %0d", last, s));
        end else if (last >= 1 && (since_step < int'(RAIL_STEP_CYCLES) - 2 ||
                                   since_step > int'(RAIL_STEP_CYCLES) + 2)) begin
          report_error($sformatf("rail step took %0d cycles", since_step));
        end
        last       = s;
        since_step = 0;
      end
    end
    max_stage = last;
  endtask

  task automatic run_vector(input int i);
    int           max_stage;
    logic         exp_ok;
    power_cause_t exp_cause;
    test_name     = $sformatf("%0s", vec_name[i]);
    cfg_atx_ok    = vec_data[i][0];
    cfg_atx_delay = vec_data[i][1];
    cfg_rails_ok  = vec_data[i][2];
    cfg_drop      = vec_data[i][3];
    exp_ok        = (vec_data[i][5] != 0);
    exp_cause     = power_cause_t'(vec_data[i][6]);
    press_button(5);  // bounce too short to count
    repeat (30) tick();
    check_bit("atx_ps_on_n_o after bounce", 1'b1, atx_ps_on_n_o);
    press_button(LONG_PRESS);
    wait_supply(1'b0, 10, "ATX supply not requested after a long press");
    run_power_up(max_stage);
    check_bit("power_ok_o after power-up", (cfg_atx_ok != 0) && (cfg_rails_ok != 0),
              power_ok_o);
    if (cfg_atx_ok == 0 && max_stage != 0) begin
      report_error("a rail was released without ATX power-good");
    end else if (cfg_atx_ok != 0 && max_stage != int'(RAIL_STAGES)) begin
      report_error("not every rail step was released");
    end
    if (power_ok_o) begin
      check_bit("atx_load_res_off_o", 1'b1, atx_load_res_off_o);
      check_bit("power LED", 1'b0, chs_led_n_o[0]);
      check_bit("action LED", 1'b0, chs_led_n_o[1]);
      if (vec_data[i][4] != 0) begin
        press_button(LONG_PRESS);
      end
      if (cfg_drop > 0 || vec_data[i][4] != 0) begin
        wait_supply(1'b1, cfg_drop + 100, "board stayed on after a drop or a press");
        check_all_off();
      end
    end else begin
      check_all_off();
    end
    check_bit("power_ok_o", exp_ok, power_ok_o);
    check_cause("power_cause_o", exp_cause, power_cause_o);
    if (!exp_ok && (exp_cause == CAUSE_ATX || exp_cause == CAUSE_RAIL)) begin
      check_power_blink();
    end else if (!exp_ok) begin
      check_bit("power LED", 1'b1, chs_led_n_o[0]);
    end
    if (power_ok_o) begin  // back to off for the next line
      press_button(LONG_PRESS);
      wait_supply(1'b1, 10, "board stayed on after the closing press");
    end
    repeat (30) tick();
  endtask

  task automatic read_vectors();
    int              fd;
    int              code;
    logic [8*24-1:0] token;
    logic [8*128-1:0] line_buf;
    fd = $fopen("verif/power_vectors.txt", "r");
    if (fd == 0) begin
      report_error("cannot open verif/power_vectors.txt");
    end else begin
      while (num_vectors < MAX_VECTORS && $fscanf(fd, "%s", token) == 1) begin
        if (token == "#") begin
          code = $fgets(line_buf, fd);  // skip the comment line
        end else begin
          code = $fscanf(fd, "%d %d %d %d %d %d %d", vec_data[num_vectors][0],
                         vec_data[num_vectors][1], vec_data[num_vectors][2],
                         vec_data[num_vectors][3], vec_data[num_vectors][4],
                         vec_data[num_vectors][5], vec_data[num_vectors][6]);
          if (code != 7) begin
            report_error("vector line with missing columns");
          end else begin
            vec_name[num_vectors] = token;
            num_vectors++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  initial begin
    int i;
    reset_i           = 1'b1;
    chs_powerdown_n_i = 1'b1;
    atx_pwr_ok_i      = 1'b0;
    aux_3v3_pg_i      = 1'b0;
    mgt_pg_i          = 3'b000;
    cfg_atx_ok        = 0;
    cfg_atx_delay     = 0;
    cfg_rails_ok      = 0;
    cfg_drop          = 0;
    atx_age           = 0;
    on_age            = 0;
    cycle_count       = 0;
    cycle_limit       = CYCLES_PER_VECTOR;
    mismatches        = 0;
    other_errors      = 0;
    num_vectors       = 0;
    test_name         = "reset";
    read_vectors();
    cycle_limit = CYCLES_PER_VECTOR * (num_vectors + 1);
    repeat (5) tick();
    reset_i = 1'b0;
    tick();
    check_bit("atx_ps_on_n_o", 1'b1, atx_ps_on_n_o);
    check_bit("atx_load_res_off_o", 1'b0, atx_load_res_off_o);
    check_bit("power_ok_o", 1'b0, power_ok_o);
    check_cause("power_cause_o", CAUSE_NONE, power_cause_o);
    check_bit("power LED", 1'b1, chs_led_n_o[0]);
    check_bit("action LED", 1'b1, chs_led_n_o[1]);
    if (rail_stage_seen() != 0) begin
      report_error("rail outputs are not in their reset state");
    end
    for (i = 0; i < num_vectors; i++) begin
      run_vector(i);
    end
    if (num_vectors == 0) begin
      report_error("no test vectors were read");
    end
    $display("vectors %0d, mismatches %0d, other errors %0d", num_vectors, mismatches,
             other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== board_power.f ====
common/board_power_pkg.sv
common/rail_ctrl_if.sv
design/button_debouncer.sv
power/sequence_timer.sv
power/power_sequencer.sv
power/rail_driver.sv
design/status_led.sv
design/board_power_top.sv
verif/board_power_tb.sv

// ==== verif/power_vectors.txt ====
# name atx_ok atx_delay rails_ok drop_cycle press_again exp_power_ok exp_cause
# causes 0 none, 1 atx, 2 rail, 3 user; drop_cycle 0 means no power-good drop
power_up        1  10 1  0 0 1 0
user_off        1  20 1  0 1 0 3
atx_missing     0   0 1  0 0 0 1
rails_missing   1  15 0  0 0 0 2
rail_drop       1  30 1 25 0 0 2
recover         1   5 1  0 0 1 2
slow_atx        1 200 1  0 1 0 3
power_up_again  1   1 1  0 0 1 3
